//--- dino_pkg.sv
/* shared types for the runner game
   game state and dino phase enums, screen coordinate and colour types,
   fixed palette in 3-3-2 packing */
package dino_pkg;

   // game mode, driven from outside the design
   typedef enum logic [1:0] {
      GAME_GRACE, // obstacles held at their start positions
      GAME_PLAY,
      GAME_DEAD   // everything frozen
   } game_state_e;

   // vertical motion of the dinosaur
   typedef enum logic [1:0] {
      DINO_RUN,
      DINO_RISE,
      DINO_FALL
   } dino_phase_e;

   typedef logic signed [11:0] coord_t; // signed so boxes can sit left of the screen

   typedef logic [7:0] rgb_t; // rrr_ggg_bb

   localparam rgb_t BG_COLOR     = 8'b000_000_00;
   localparam rgb_t FLOOR_COLOR  = 8'b101_011_00; // sandy brown
   localparam rgb_t CACTUS_COLOR = 8'b000_110_00;
   localparam rgb_t BIRD_COLOR   = 8'b011_011_10;
   localparam rgb_t DINO_COLOR   = 8'b110_110_11;

endpackage

//--- vga_timing.sv
`timescale 1ns/1ps
/* raster timing generator with pixel strobe divider, position counters,
   negative syncs, active flag and end-of-frame strobe */
module vga_timing #(
   parameter int H_ACTIVE    = 640,
   parameter int H_FP        = 16,
   parameter int H_SYNC      = 96,
   parameter int H_BP        = 48,
   parameter int V_ACTIVE    = 480,
   parameter int V_FP        = 10,
   parameter int V_SYNC      = 2,
   parameter int V_BP        = 33,
   parameter int CLK_PER_PIX = 4
) (
   input  logic             i_clk,
   input  logic             i_arst_n,
   output logic             o_pix_stb,
   output logic             o_hs,
   output logic             o_vs,
   output logic             o_active,
   output logic             o_frame,
   output dino_pkg::coord_t o_x,
   output dino_pkg::coord_t o_y
);
   import dino_pkg::*;

   localparam int     DIV_W    = $clog2(CLK_PER_PIX + 1);
   localparam coord_t H_LAST   = coord_t'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
   localparam coord_t V_LAST   = coord_t'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);
   localparam coord_t HS_START = coord_t'(H_ACTIVE + H_FP);
   localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FP + H_SYNC);
   localparam coord_t VS_START = coord_t'(V_ACTIVE + V_FP);
   localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FP + V_SYNC);

   logic [DIV_W-1:0] div_cnt;
   coord_t           h_cnt;
   coord_t           v_cnt;

   assign o_pix_stb = (div_cnt == DIV_W'(CLK_PER_PIX - 1));

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         div_cnt <= '0;
      end else if (o_pix_stb) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + DIV_W'(1);
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (o_pix_stb) begin
         if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + coord_t'(1); // next line or wrap
         end else begin
            h_cnt <= h_cnt + coord_t'(1);
         end
      end
   end

   assign o_x      = h_cnt;
   assign o_y      = v_cnt;
   assign o_hs     = !((h_cnt >= HS_START) && (h_cnt < HS_END)); // low during sync
   assign o_vs     = !((v_cnt >= VS_START) && (v_cnt < VS_END));
   assign o_active = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));
   // last visible pixel leaves the screen on this strobe
   assign o_frame  = o_pix_stb && (h_cnt == coord_t'(H_ACTIVE - 1))
                     && (v_cnt == coord_t'(V_ACTIVE - 1));

   // frame strobe rides a pixel strobe and the raster then leaves the visible area
   a_frame_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_frame |-> o_pix_stb ##1 !o_active);

endmodule

//--- obstacle.sv
`timescale 1ns/1ps
/* one obstacle box that steps left once per frame and wraps to the right */
module obstacle #(
   parameter int START_X    = 640,
   parameter int TOP_Y      = 370,
   parameter int WIDTH      = 12,
   parameter int HEIGHT     = 30,
   parameter int OBST_SPEED = 4,
   parameter int WRAP_X     = 640
) (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  logic                  i_frame,
   input  dino_pkg::game_state_e i_state,
   output dino_pkg::coord_t      o_x1,
   output dino_pkg::coord_t      o_x2,
   output dino_pkg::coord_t      o_y1,
   output dino_pkg::coord_t      o_y2
);
   import dino_pkg::*;

   localparam coord_t BOX_W = coord_t'(WIDTH);
   localparam coord_t STEP  = coord_t'(OBST_SPEED);

   coord_t x1;
   coord_t x1_step;

   assign x1_step = x1 - STEP;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         x1 <= coord_t'(START_X);
      end else if (i_frame) begin
         case (i_state)
            GAME_GRACE: x1 <= coord_t'(START_X);
            GAME_PLAY: begin
               if (x1_step + BOX_W <= coord_t'(0)) begin
                  x1 <= coord_t'(WRAP_X); // fully off the left edge
               end else begin
                  x1 <= x1_step;
               end
            end
            default: x1 <= x1; // dead, box frozen
         endcase
      end
   end

   assign o_x1 = x1;
   assign o_x2 = x1 + BOX_W;
   assign o_y1 = coord_t'(TOP_Y);
   assign o_y2 = coord_t'(TOP_Y + HEIGHT);

   // a moved box stays ordered and never sits wholly left of column 0
   a_box_order: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_frame && i_state == GAME_PLAY) |=> (o_x1 < o_x2) && (o_x2 > coord_t'(0)));

endmodule

//--- dino_player.sv
`timescale 1ns/1ps
/* dinosaur box with a run, rise and fall FSM stepped per frame,
   and a half-height box while ducking on the ground */
module dino_player #(
   parameter int DINO_X      = 60,
   parameter int DINO_W      = 20,
   parameter int DINO_H      = 40,
   parameter int FLOOR_Y     = 400,
   parameter int JUMP_STEP   = 6,
   parameter int JUMP_FRAMES = 16
) (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  logic                  i_frame,
   input  logic                  i_jump,
   input  logic                  i_duck,
   input  dino_pkg::game_state_e i_state,
   output dino_pkg::coord_t      o_x1,
   output dino_pkg::coord_t      o_x2,
   output dino_pkg::coord_t      o_y1,
   output dino_pkg::coord_t      o_y2
);
   import dino_pkg::*;

   localparam int     CNT_W = $clog2(JUMP_FRAMES + 1);
   localparam coord_t STEP  = coord_t'(JUMP_STEP);
   localparam coord_t FLOOR = coord_t'(FLOOR_Y);

   dino_phase_e      phase;
   dino_phase_e      phase_nxt;
   logic [CNT_W-1:0] cnt;     // rise steps taken so far
   logic [CNT_W-1:0] cnt_nxt;
   coord_t           lift;    // height of the box bottom above the floor
   coord_t           lift_nxt;
   logic             ducked;
   logic             ducked_nxt;

   always_comb begin
      phase_nxt = phase;
      cnt_nxt   = cnt;
      lift_nxt  = lift;
      case (phase)
         DINO_RUN: begin
            if (i_jump) begin
               phase_nxt = DINO_RISE;
               lift_nxt  = STEP; // leave the ground on this frame
               cnt_nxt   = CNT_W'(1);
            end
         end
         DINO_RISE: begin
            if (cnt < CNT_W'(JUMP_FRAMES)) begin
               lift_nxt = lift + STEP;
               cnt_nxt  = cnt + CNT_W'(1);
            end else begin
               phase_nxt = DINO_FALL; // top of the arc reached
               lift_nxt  = lift - STEP;
            end
         end
         DINO_FALL: begin
            if (lift <= STEP) begin
               phase_nxt = DINO_RUN;
               lift_nxt  = '0;
               cnt_nxt   = '0;
            end else begin
               lift_nxt = lift - STEP;
            end
         end
         default: begin
            phase_nxt = DINO_RUN;
            lift_nxt  = '0;
            cnt_nxt   = '0;
         end
      endcase
      ducked_nxt = (phase_nxt == DINO_RUN) && i_duck; // no ducking in the air
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         phase  <= DINO_RUN;
         cnt    <= '0;
         lift   <= '0;
         ducked <= 1'b0;
      end else if (i_frame && i_state != GAME_DEAD) begin
         phase  <= phase_nxt;
         cnt    <= cnt_nxt;
         lift   <= lift_nxt;
         ducked <= ducked_nxt;
      end
   end

   assign o_x1 = coord_t'(DINO_X);
   assign o_x2 = coord_t'(DINO_X + DINO_W);
   assign o_y2 = FLOOR - lift;
   assign o_y1 = o_y2 - (ducked ? coord_t'(DINO_H / 2) : coord_t'(DINO_H));

   // never below the floor, and standing on it whenever the FSM says run
   a_on_floor: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (o_y2 <= FLOOR) && ((phase != DINO_RUN) || (o_y2 == FLOOR)));

endmodule

//--- pixel_compositor.sv
`timescale 1ns/1ps
/* per-pixel box hit tests, priority colour select, collision flag
   and the output registers that keep colour aligned with sync */
module pixel_compositor #(
   parameter int NUM_CACTI = 3,
   parameter int NUM_BIRDS = 1,
   parameter int FLOOR_Y   = 400
) (
   input  logic                                           i_clk,
   input  logic                                           i_arst_n,
   input  logic                                           i_pix_stb,
   input  logic                                           i_hs,
   input  logic                                           i_vs,
   input  logic                                           i_active,
   input  dino_pkg::coord_t                               i_x,
   input  dino_pkg::coord_t                               i_y,
   input  logic [NUM_CACTI*$bits(dino_pkg::coord_t)-1:0] i_cactus_x1,
   input  logic [NUM_CACTI*$bits(dino_pkg::coord_t)-1:0] i_cactus_x2,
   input  logic [NUM_CACTI*$bits(dino_pkg::coord_t)-1:0] i_cactus_y1,
   input  logic [NUM_CACTI*$bits(dino_pkg::coord_t)-1:0] i_cactus_y2,
   input  logic [NUM_BIRDS*$bits(dino_pkg::coord_t)-1:0] i_bird_x1,
   input  logic [NUM_BIRDS*$bits(dino_pkg::coord_t)-1:0] i_bird_x2,
   input  logic [NUM_BIRDS*$bits(dino_pkg::coord_t)-1:0] i_bird_y1,
   input  logic [NUM_BIRDS*$bits(dino_pkg::coord_t)-1:0] i_bird_y2,
   input  dino_pkg::coord_t                               i_dino_x1,
   input  dino_pkg::coord_t                               i_dino_x2,
   input  dino_pkg::coord_t                               i_dino_y1,
   input  dino_pkg::coord_t                               i_dino_y2,
   output logic                                           o_hs,
   output logic                                           o_vs,
   output logic                                           o_active,
   output logic                                           o_collision,
   output logic [2:0]                                     o_red,
   output logic [2:0]                                     o_green,
   output logic [1:0]                                     o_blue
);
   import dino_pkg::*;

   localparam int CW = $bits(coord_t);

   logic [NUM_CACTI-1:0] cactus_hit;
   logic [NUM_BIRDS-1:0] bird_hit;
   logic                 dino_hit;
   logic                 floor_hit;
   logic                 collide;
   rgb_t                 color;

   // edges follow the half-open convention x1 <= x < x2
   function automatic logic in_box(input coord_t x, input coord_t y,
                                   input coord_t x1, input coord_t x2,
                                   input coord_t y1, input coord_t y2);
      return (x >= x1) && (x < x2) && (y >= y1) && (y < y2);
   endfunction

   for (genvar i = 0; i < NUM_CACTI; i++) begin : g_cactus_hit
      assign cactus_hit[i] = in_box(i_x, i_y,
                                    coord_t'(i_cactus_x1[i*CW +: CW]),
                                    coord_t'(i_cactus_x2[i*CW +: CW]),
                                    coord_t'(i_cactus_y1[i*CW +: CW]),
                                    coord_t'(i_cactus_y2[i*CW +: CW]));
   end

   for (genvar i = 0; i < NUM_BIRDS; i++) begin : g_bird_hit
      assign bird_hit[i] = in_box(i_x, i_y,
                                  coord_t'(i_bird_x1[i*CW +: CW]),
                                  coord_t'(i_bird_x2[i*CW +: CW]),
                                  coord_t'(i_bird_y1[i*CW +: CW]),
                                  coord_t'(i_bird_y2[i*CW +: CW]));
   end

   assign dino_hit  = in_box(i_x, i_y, i_dino_x1, i_dino_x2, i_dino_y1, i_dino_y2);
   assign floor_hit = (i_y >= coord_t'(FLOOR_Y));
   assign collide   = i_active && dino_hit && ((|cactus_hit) || (|bird_hit));

   always_comb begin
      if (!i_active) begin
         color = 8'h00; // blanking must be black
      end else if (dino_hit) begin
         color = DINO_COLOR;
      end else if (|bird_hit) begin
         color = BIRD_COLOR;
      end else if (|cactus_hit) begin
         color = CACTUS_COLOR;
      end else if (floor_hit) begin
         color = FLOOR_COLOR;
      end else begin
         color = BG_COLOR;
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_hs                     <= 1'b1;
         o_vs                     <= 1'b1;
         o_active                 <= 1'b0;
         o_collision              <= 1'b0;
         {o_red, o_green, o_blue} <= BG_COLOR;
      end else if (i_pix_stb) begin
         o_hs                     <= i_hs;
         o_vs                     <= i_vs;
         o_active                 <= i_active;
         o_collision              <= collide;
         {o_red, o_green, o_blue} <= color;
      end
   end

   // a collision sits on a visible pixel and visible pixels never overlap a sync pulse
   a_collision_px: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_collision |-> o_active && o_hs && o_vs);

endmodule

//--- dino_game_top.sv
`timescale 1ns/1ps
/* runner game top level with raster timing, cactus and bird rows,
   the dinosaur player and the pixel compositor */
module dino_game_top #(
   parameter int H_ACTIVE    = 640,
   parameter int H_FP        = 16,
   parameter int H_SYNC      = 96,
   parameter int H_BP        = 48,
   parameter int V_ACTIVE    = 480,
   parameter int V_FP        = 10,
   parameter int V_SYNC      = 2,
   parameter int V_BP        = 33,
   parameter int CLK_PER_PIX = 4,
   parameter int FLOOR_Y     = 400,
   parameter int NUM_CACTI   = 3,
   parameter int NUM_BIRDS   = 1,
   parameter int OBST_SPEED  = 4,
   parameter int OBST_GAP    = 240,
   parameter int JUMP_STEP   = 6,
   parameter int JUMP_FRAMES = 16,
   parameter int DINO_X      = 60,
   parameter int DINO_W      = 20,
   parameter int DINO_H      = 40,
   parameter int CACTUS_W    = 12,
   parameter int CACTUS_H    = 30,
   parameter int BIRD_W      = 16,
   parameter int BIRD_H      = 10
) (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  logic                  i_jump,
   input  logic                  i_duck,
   input  dino_pkg::game_state_e i_state,
   output logic                  o_hs,
   output logic                  o_vs,
   output logic                  o_active,
   output logic                  o_collision,
   output logic [2:0]            o_red,
   output logic [2:0]            o_green,
   output logic [1:0]            o_blue
);
   import dino_pkg::*;

   localparam int CW          = $bits(coord_t);
   localparam int CACTUS_WRAP = H_ACTIVE + (NUM_CACTI - 1) * OBST_GAP; // behind the last one
   localparam int BIRD_X0     = H_ACTIVE + OBST_GAP / 2; // birds sit between cacti
   localparam int BIRD_WRAP   = BIRD_X0 + (NUM_BIRDS - 1) * OBST_GAP;
   localparam int BIRD_Y2     = FLOOR_Y - DINO_H / 2 - 2; // clears a ducking dino

   logic   pix_stb;
   logic   frame;
   logic   hs;
   logic   vs;
   logic   active;
   coord_t pix_x;
   coord_t pix_y;

   logic [NUM_CACTI*CW-1:0] cactus_x1, cactus_x2, cactus_y1, cactus_y2;
   logic [NUM_BIRDS*CW-1:0] bird_x1, bird_x2, bird_y1, bird_y2;
   coord_t                  dino_x1, dino_x2, dino_y1, dino_y2;

   vga_timing #(
      .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
      .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP),
      .CLK_PER_PIX (CLK_PER_PIX)
   ) u_timing (
      .i_clk     (i_clk),
      .i_arst_n  (i_arst_n),
      .o_pix_stb (pix_stb),
      .o_hs      (hs),
      .o_vs      (vs),
      .o_active  (active),
      .o_frame   (frame),
      .o_x       (pix_x),
      .o_y       (pix_y)
   );

   for (genvar i = 0; i < NUM_CACTI; i++) begin : g_cactus
      obstacle #(
         .START_X    (H_ACTIVE + i * OBST_GAP),
         .TOP_Y      (FLOOR_Y - CACTUS_H),
         .WIDTH      (CACTUS_W),
         .HEIGHT     (CACTUS_H),
         .OBST_SPEED (OBST_SPEED),
         .WRAP_X     (CACTUS_WRAP)
      ) u_cactus (
         .i_clk    (i_clk),
         .i_arst_n (i_arst_n),
         .i_frame  (frame),
         .i_state  (i_state),
         .o_x1     (cactus_x1[i*CW +: CW]),
         .o_x2     (cactus_x2[i*CW +: CW]),
         .o_y1     (cactus_y1[i*CW +: CW]),
         .o_y2     (cactus_y2[i*CW +: CW])
      );
   end

   for (genvar i = 0; i < NUM_BIRDS; i++) begin : g_bird
      obstacle #(
         .START_X    (BIRD_X0 + i * OBST_GAP),
         .TOP_Y      (BIRD_Y2 - BIRD_H),
         .WIDTH      (BIRD_W),
         .HEIGHT     (BIRD_H),
         .OBST_SPEED (OBST_SPEED),
         .WRAP_X     (BIRD_WRAP)
      ) u_bird (
         .i_clk    (i_clk),
         .i_arst_n (i_arst_n),
         .i_frame  (frame),
         .i_state  (i_state),
         .o_x1     (bird_x1[i*CW +: CW]),
         .o_x2     (bird_x2[i*CW +: CW]),
         .o_y1     (bird_y1[i*CW +: CW]),
         .o_y2     (bird_y2[i*CW +: CW])
      );
   end

   dino_player #(
      .DINO_X (DINO_X), .DINO_W (DINO_W), .DINO_H (DINO_H), .FLOOR_Y (FLOOR_Y),
      .JUMP_STEP (JUMP_STEP), .JUMP_FRAMES (JUMP_FRAMES)
   ) u_dino (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_frame  (frame),
      .i_jump   (i_jump),
      .i_duck   (i_duck),
      .i_state  (i_state),
      .o_x1     (dino_x1),
      .o_x2     (dino_x2),
      .o_y1     (dino_y1),
      .o_y2     (dino_y2)
   );

   pixel_compositor #(
      .NUM_CACTI (NUM_CACTI), .NUM_BIRDS (NUM_BIRDS), .FLOOR_Y (FLOOR_Y)
   ) u_compositor (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_pix_stb   (pix_stb),
      .i_hs        (hs),
      .i_vs        (vs),
      .i_active    (active),
      .i_x         (pix_x),
      .i_y         (pix_y),
      .i_cactus_x1 (cactus_x1),
      .i_cactus_x2 (cactus_x2),
      .i_cactus_y1 (cactus_y1),
      .i_cactus_y2 (cactus_y2),
      .i_bird_x1   (bird_x1),
      .i_bird_x2   (bird_x2),
      .i_bird_y1   (bird_y1),
      .i_bird_y2   (bird_y2),
      .i_dino_x1   (dino_x1),
      .i_dino_x2   (dino_x2),
      .i_dino_y1   (dino_y1),
      .i_dino_y2   (dino_y2),
      .o_hs        (o_hs),
      .o_vs        (o_vs),
      .o_active    (o_active),
      .o_collision (o_collision),
      .o_red       (o_red),
      .o_green     (o_green),
      .o_blue      (o_blue)
   );

endmodule

//--- tb_dino_game.sv
`timescale 1ns/1ps
/* runner game testbench with clock, reset, stimulus table,
   frame scanner, reference model of boxes and colours and checks */
module tb_dino_game;
   import dino_pkg::*;

   localparam int H_ACTIVE = 64, H_FP = 4, H_SYNC = 8, H_BP = 4;
   localparam int V_ACTIVE = 48, V_FP = 2, V_SYNC = 2, V_BP = 4;
   localparam int CPP         = 4;
   localparam int FLOOR_Y     = 40;
   localparam int OBST_SPEED  = 4;
   localparam int OBST_GAP    = 200;
   localparam int JUMP_STEP   = 2;
   localparam int JUMP_FRAMES = 4;
   localparam int DINO_X = 8, DINO_W = 6, DINO_H = 10;
   localparam int CACTUS_W = 4, CACTUS_H = 6, BIRD_W = 6, BIRD_H = 3;
   localparam int H_TOTAL     = H_ACTIVE + H_FP + H_SYNC + H_BP;
   localparam int V_TOTAL     = V_ACTIVE + V_FP + V_SYNC + V_BP;
   localparam int FRAME_CLKS  = H_TOTAL * V_TOTAL * CPP;
   localparam int CACTUS_X0   = H_ACTIVE; // start and wrap column of the single cactus
   localparam int BIRD_X0     = H_ACTIVE + OBST_GAP / 2;
   localparam int BIRD_Y2     = FLOOR_Y - DINO_H / 2 - 2;
   localparam int NUM_ROWS    = 11;
   localparam int TOTAL_FRAMES = 51;
   localparam int TIMEOUT     = (TOTAL_FRAMES + 2) * FRAME_CLKS;

   logic        i_clk, i_arst_n, i_jump, i_duck;
   game_state_e i_state;
   logic        o_hs, o_vs, o_active, o_collision;
   logic [2:0]  o_red, o_green;
   logic [1:0]  o_blue;
   int          cycle_cnt;

   // stimulus table whose expected values belong to the last frame of each row
   string       tbl_name  [NUM_ROWS] = '{"timing_grace", "duck_grace", "jump_start",
      "jump_arc", "scroll", "collide", "dead_freeze", "wrap", "run_up", "jump_clear",
      "clear_land"};
   game_state_e tbl_state [NUM_ROWS] = '{GAME_GRACE, GAME_GRACE, GAME_GRACE, GAME_GRACE,
      GAME_PLAY, GAME_PLAY, GAME_DEAD, GAME_PLAY, GAME_PLAY, GAME_PLAY, GAME_PLAY};
   bit          tbl_jump  [NUM_ROWS] = '{0, 0, 1, 0, 0, 0, 1, 0, 0, 1, 0};
   bit          tbl_duck  [NUM_ROWS] = '{0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0};
   int          tbl_frames[NUM_ROWS] = '{2, 2, 1, 10, 10, 5, 2, 3, 9, 1, 6};
   int          tbl_top   [NUM_ROWS] = '{30, 35, 35, 30, 30, 30, 30, 30, 30, 30, 26};
   int          tbl_col   [NUM_ROWS] = '{-1, -1, -1, -1, 28, -1, 4, -1, 28, 24, 0};
   bit          tbl_coll  [NUM_ROWS] = '{0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0};

   // reference model state
   int          m_cactus_x, m_bird_x, m_lift, m_cnt;
   dino_phase_e m_phase;
   bit          m_ducked;

   dino_game_top #(
      .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
      .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP),
      .CLK_PER_PIX (CPP), .FLOOR_Y (FLOOR_Y), .NUM_CACTI (1), .NUM_BIRDS (1),
      .OBST_SPEED (OBST_SPEED), .OBST_GAP (OBST_GAP), .JUMP_STEP (JUMP_STEP),
      .JUMP_FRAMES (JUMP_FRAMES), .DINO_X (DINO_X), .DINO_W (DINO_W), .DINO_H (DINO_H),
      .CACTUS_W (CACTUS_W), .CACTUS_H (CACTUS_H), .BIRD_W (BIRD_W), .BIRD_H (BIRD_H)
   ) dut (
      .i_clk (i_clk), .i_arst_n (i_arst_n), .i_jump (i_jump), .i_duck (i_duck),
      .i_state (i_state), .o_hs (o_hs), .o_vs (o_vs), .o_active (o_active),
      .o_collision (o_collision), .o_red (o_red), .o_green (o_green), .o_blue (o_blue)
   );

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > TIMEOUT) begin
         $display("test failed");
         $fatal(1, "simulation ran past the cycle limit without finishing the table");
      end
   end

   task automatic check_int(input string test, input string what, input int exp,
                            input int act);
      assert (exp == act) else begin
         $display("Fail %s %s: expected %0d actual %0d", test, what, exp, act);
         $display("test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic bit in_box(input int x, input int y, input int x1, input int x2,
                                 input int y1, input int y2);
      return (x >= x1) && (x < x2) && (y >= y1) && (y < y2);
   endfunction

   function automatic int dino_y1();
      return FLOOR_Y - m_lift - (m_ducked ? DINO_H / 2 : DINO_H);
   endfunction

   function automatic bit dino_at(input int x, input int y);
      return in_box(x, y, DINO_X, DINO_X + DINO_W, dino_y1(), FLOOR_Y - m_lift);
   endfunction

   function automatic bit obst_at(input int x, input int y);
      return in_box(x, y, m_cactus_x, m_cactus_x + CACTUS_W, FLOOR_Y - CACTUS_H, FLOOR_Y)
          || in_box(x, y, m_bird_x, m_bird_x + BIRD_W, BIRD_Y2 - BIRD_H, BIRD_Y2);
   endfunction

   // colour by priority dino, bird, cactus, floor, background
   function automatic int model_color(input int x, input int y);
      if (dino_at(x, y)) return int'(DINO_COLOR);
      if (in_box(x, y, m_bird_x, m_bird_x + BIRD_W, BIRD_Y2 - BIRD_H, BIRD_Y2))
         return int'(BIRD_COLOR);
      if (in_box(x, y, m_cactus_x, m_cactus_x + CACTUS_W, FLOOR_Y - CACTUS_H, FLOOR_Y))
         return int'(CACTUS_COLOR);
      if (y >= FLOOR_Y) return int'(FLOOR_COLOR);
      return int'(BG_COLOR);
   endfunction

   function automatic int model_cactus_col();
      for (int x = 0; x < H_ACTIVE; x++) begin
         if (model_color(x, FLOOR_Y - 1) == int'(CACTUS_COLOR)) return x;
      end
      return -1;
   endfunction

   function automatic int step_obst(input int x1, input int w, input int wrap_x);
      return (x1 - OBST_SPEED + w <= 0) ? wrap_x : x1 - OBST_SPEED;
   endfunction

   // one frame strobe worth of game rules
   task automatic model_update(input game_state_e st, input bit jump, input bit duck);
      if (st == GAME_GRACE) begin
         m_cactus_x = CACTUS_X0;
         m_bird_x   = BIRD_X0;
      end else if (st == GAME_PLAY) begin
         m_cactus_x = step_obst(m_cactus_x, CACTUS_W, CACTUS_X0);
         m_bird_x   = step_obst(m_bird_x, BIRD_W, BIRD_X0);
      end
      if (st != GAME_DEAD) begin
         case (m_phase)
            DINO_RUN: if (jump) begin
               m_phase = DINO_RISE;
               m_lift  = JUMP_STEP;
               m_cnt   = 1;
            end
            DINO_RISE: if (m_cnt < JUMP_FRAMES) begin
               m_lift += JUMP_STEP;
               m_cnt++;
            end else begin
               m_phase = DINO_FALL;
               m_lift -= JUMP_STEP;
            end
            default: if (m_lift <= JUMP_STEP) begin
               m_phase = DINO_RUN;
               m_lift  = 0;
               m_cnt   = 0;
            end else begin
               m_lift -= JUMP_STEP;
            end
         endcase
         m_ducked = (m_phase == DINO_RUN) && duck;
      end
   endtask

   // starts right after vsync ends and runs until the next vsync ends
   task automatic run_frame(input int row, output int top, output int col, output bit coll);
      int  line;
      int  col_clk;
      int  hs_clks;
      int  vs_clks;
      int  px;
      bit  prev_active;
      bit  done;
      string name;
      name = tbl_name[row];
      line = -1;
      col_clk = 0;
      hs_clks = 0;
      prev_active = 1'b0;
      done = 1'b0;
      top = -1;
      col = -1;
      coll = 1'b0;
      @(posedge i_clk);
      i_state <= tbl_state[row];
      i_jump  <= tbl_jump[row];
      i_duck  <= tbl_duck[row];
      while (!done) begin
         @(negedge i_clk);
         if (!o_vs) begin
            done = 1'b1;
         end else begin
            if (o_active && !prev_active) begin
               line++;
               col_clk = 0;
            end
            if (!o_active && prev_active)
               check_int(name, "active clocks per line", H_ACTIVE * CPP, col_clk);
            if (!o_hs) begin
               hs_clks++;
            end else if (hs_clks > 0) begin
               check_int(name, "hsync clocks", H_SYNC * CPP, hs_clks);
               hs_clks = 0;
            end
            if (o_active) begin
               px = col_clk / CPP;
               if (col_clk % CPP == 0) begin
                  check_int(name, "pixel colour", model_color(px, line),
                            int'({o_red, o_green, o_blue}));
                  check_int(name, "pixel collision", int'(dino_at(px, line) && obst_at(px, line)),
                            int'(o_collision));
                  if (top < 0 && {o_red, o_green, o_blue} == DINO_COLOR) top = line;
                  if (col < 0 && line == FLOOR_Y - 1 && {o_red, o_green, o_blue} == CACTUS_COLOR)
                     col = px;
                  if (o_collision) coll = 1'b1;
               end
               col_clk++;
            end
            prev_active = o_active;
         end
      end
      check_int(name, "active lines", V_ACTIVE, line + 1);
      vs_clks = 1;
      while (!o_vs) begin
         @(negedge i_clk);
         if (!o_vs) vs_clks++;
      end
      check_int(name, "vsync clocks", V_SYNC * H_TOTAL * CPP, vs_clks);
      check_int(name, "dino top row", dino_y1(), top);
      check_int(name, "first cactus column", model_cactus_col(), col);
      model_update(tbl_state[row], tbl_jump[row], tbl_duck[row]);
   endtask

   initial begin
      int top, col, prev_top, prev_col;
      bit coll, row_coll;
      void'($urandom(32'h9db));
      i_arst_n  = 1'b0;
      i_jump    = 1'b0;
      i_duck    = 1'b0;
      i_state   = GAME_GRACE;
      cycle_cnt = 0;
      m_cactus_x = CACTUS_X0;
      m_bird_x   = BIRD_X0;
      m_phase    = DINO_RUN;
      m_lift     = 0;
      m_cnt      = 0;
      m_ducked   = 1'b0;
      repeat (3) @(posedge i_clk);
      i_arst_n <= 1'b1;
      @(negedge i_clk);
      while (o_vs) @(negedge i_clk); // skip the first partial frame
      while (!o_vs) @(negedge i_clk);
      for (int r = 0; r < NUM_ROWS; r++) begin
         row_coll = 1'b0;
         prev_top = -1;
         prev_col = -1;
         for (int f = 0; f < tbl_frames[r]; f++) begin
            run_frame(r, top, col, coll);
            row_coll |= coll;
            if (tbl_state[r] == GAME_DEAD && f > 0) begin
               check_int(tbl_name[r], "frozen dino top", prev_top, top);
               check_int(tbl_name[r], "frozen cactus column", prev_col, col);
            end
            prev_top = top;
            prev_col = col;
         end
         check_int(tbl_name[r], "table dino top", tbl_top[r], top);
         check_int(tbl_name[r], "table cactus column", tbl_col[r], col);
         check_int(tbl_name[r], "collision seen", int'(tbl_coll[r]), int'(row_coll));
      end
      $display("test passed");
      $finish;
   end

endmodule

//--- list.f
dino_pkg.sv
vga_timing.sv
obstacle.sv
dino_player.sv
pixel_compositor.sv
dino_game_top.sv
tb_dino_game.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the runner game testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert \
   --top-module tb_dino_game \
   -f list.f \
   -o sim_dino_game
status=$?
if [ $status -ne 0 ]; then
   echo "compile failed with status $status"
   exit $status
fi

./obj_dir/sim_dino_game
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

echo "simulation finished cleanly"
exit 0
